/* flist.f */
+incdir+rtl
+incdir+test
rtl/radiant_bus_pkg.sv
rtl/radiant_scal_pkg.sv
rtl/radiant_reg_if.sv
rtl/radiant_axil_decode.sv
rtl/radiant_scaler_bank.sv
rtl/radiant_read_result.sv
rtl/radiant_top.sv
test/tb_radiant_top.sv

/* rtl/radiant_axil_decode.sv */
`include "radiant_cfg.svh"

module radiant_axil_decode
    import radiant_bus_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    // write address / data
    input  axil_addr_t           s_axil_awaddr_i,
    input  logic                 s_axil_awvalid_i,
    output logic                 s_axil_awready_o,
    input  axil_data_t           s_axil_wdata_i,
    input  axil_strb_t           s_axil_wstrb_i,
    input  logic                 s_axil_wvalid_i,
    output logic                 s_axil_wready_o,
    // write response
    output axil_resp_t           s_axil_bresp_o,
    output logic                 s_axil_bvalid_o,
    input  logic                 s_axil_bready_i,
    // read address
    input  axil_addr_t           s_axil_araddr_i,
    input  logic                 s_axil_arvalid_i,
    output logic                 s_axil_arready_o,
    // read response pending in the result stage
    input  logic                 s_axil_rvalid_i,
    // read accepted, mapped or not
    output logic                 s_axil_rd_start_o,
    radiant_reg_if.decode        reg_if
);

    axil_wstate_t wstate;
    axil_resp_t bresp_q;
    logic wr_accept;
    reg_idx_t aw_idx;
    reg_idx_t ar_idx;

    // true for 0..3 and 8..31, the 4..7 hole is unmapped
    function automatic logic idx_mapped(input reg_idx_t idx);
        return (idx <= `RADIANT_REG_PPSCNT) || (idx >= `RADIANT_REG_SCAL0);
    endfunction

    // drop the byte lane bits
    assign aw_idx = s_axil_awaddr_i[`RADIANT_ADDR_W-1:2];
    assign ar_idx = s_axil_araddr_i[`RADIANT_ADDR_W-1:2];

    // aw and w only go together, one write in flight
    assign wr_accept = (wstate == wst_idle) && s_axil_awvalid_i && s_axil_wvalid_i;
    assign s_axil_awready_o = wr_accept;
    assign s_axil_wready_o = wr_accept;

    // only the mask is writable
    assign reg_if.wr_en = wr_accept && (aw_idx == `RADIANT_REG_MASK);
    assign reg_if.wr_idx = aw_idx;
    assign reg_if.wr_data = s_axil_wdata_i;
    assign reg_if.wr_strb = s_axil_wstrb_i;

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wstate <= wst_idle;
            bresp_q <= axil_resp_okay;
        end else begin
            case (wstate)
                wst_idle: begin
                    if (wr_accept) begin
                        wstate <= wst_resp;
                        // anything but the mask is refused
                        bresp_q <= (aw_idx == `RADIANT_REG_MASK) ? axil_resp_okay
                                                                 : axil_resp_slverr;
                    end
                end
                wst_resp: begin
                    // hold until the master takes it
                    if (s_axil_bready_i) begin
                        wstate <= wst_idle;
                    end
                end
                default: begin
                    wstate <= wst_idle;
                end
            endcase
        end
    end

    assign s_axil_bvalid_o = (wstate == wst_resp);
    assign s_axil_bresp_o = bresp_q;

    // no new read while a response is waiting
    assign s_axil_arready_o = !s_axil_rvalid_i;
    assign s_axil_rd_start_o = s_axil_arvalid_i && s_axil_arready_o;

    // unmapped reads still start, just without rd_en
    assign reg_if.rd_en = s_axil_rd_start_o && idx_mapped(ar_idx);
    assign reg_if.rd_idx = ar_idx;

    // write response must not drop or change under back-pressure
    a_bvalid_hold: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o));

    // every accepted read, mapped or not, is answered on the next cycle
    a_rd_resp: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        s_axil_rd_start_o |=> s_axil_rvalid_i);

endmodule

/* rtl/radiant_bus_pkg.sv */
`include "radiant_cfg.svh"

package radiant_bus_pkg;

    // byte address on the AXI4-Lite port
    typedef logic [`RADIANT_ADDR_W-1:0] axil_addr_t;

    // data word and its byte strobe
    typedef logic [`RADIANT_DATA_W-1:0] axil_data_t;
    typedef logic [`RADIANT_DATA_W/8-1:0] axil_strb_t;

    // bresp / rresp encoding
    typedef logic [1:0] axil_resp_t;
    localparam axil_resp_t axil_resp_okay = 2'b00;
    localparam axil_resp_t axil_resp_slverr = 2'b10;

    // word index, byte address minus the two lane bits
    typedef logic [`RADIANT_ADDR_W-3:0] reg_idx_t;

    // write channel FSM
    // idle waits for aw+w together, resp holds bvalid
    typedef enum logic {
        wst_idle,
        wst_resp
    } axil_wstate_t;

endpackage

/* rtl/radiant_cfg.svh */
`ifndef RADIANT_CFG_SVH
`define RADIANT_CFG_SVH

// trigger channel count and scaler width
`define RADIANT_NUM_CH 24
`define RADIANT_SCAL_W 16

// bus geometry
// byte address, 32 words of 4 bytes
`define RADIANT_ADDR_W 7
`define RADIANT_DATA_W 32

// device ident, ascii "RDNT"
`define RADIANT_IDENT 32'h5244_4e54

// firmware version fields
`define RADIANT_VER_MAJOR 4'd0
`define RADIANT_VER_MINOR 4'd3
`define RADIANT_VER_REV 8'd3
// packed date field: year[15:9], month[8:5], day[4:0]
// left zero, stamped by the release flow
`define RADIANT_FW_DATE 16'h0000
// date in upper half, major/minor/rev in lower half
`define RADIANT_DATEVER {`RADIANT_FW_DATE, `RADIANT_VER_MAJOR, `RADIANT_VER_MINOR, `RADIANT_VER_REV}

// per-channel input polarity, 1 = active low
`define RADIANT_TRIG_POL 24'h6c_9296

// word indexes of the register map
`define RADIANT_REG_ID 5'd0
`define RADIANT_REG_DATEVER 5'd1
`define RADIANT_REG_MASK 5'd2
`define RADIANT_REG_PPSCNT 5'd3
// scaler n lives at index 8 + n
// indexes 4..7 are a hole
`define RADIANT_REG_SCAL0 5'd8

`endif

/* rtl/radiant_read_result.sv */
`include "radiant_cfg.svh"

module radiant_read_result
    import radiant_bus_pkg::*, radiant_scal_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    // read accepted by the front end
    input  logic                 rd_start_i,
    radiant_reg_if.result        reg_if,
    // live register values from the scaler bank
    input  ch_mask_t             mask_i,
    input  axil_data_t           pps_cnt_i,
    input  scal_array_t          scal_i,
    // read data channel
    output axil_data_t           s_axil_rdata_o,
    output axil_resp_t           s_axil_rresp_o,
    output logic                 s_axil_rvalid_o,
    input  logic                 s_axil_rready_i
);

    axil_data_t rd_word;
    reg_idx_t scal_sel;

    // scaler slot relative to the first scaler word
    assign scal_sel = reg_if.rd_idx - `RADIANT_REG_SCAL0;

    always_comb begin
        rd_word = '0;
        case (reg_if.rd_idx)
            `RADIANT_REG_ID:      rd_word = `RADIANT_IDENT;
            `RADIANT_REG_DATEVER: rd_word = `RADIANT_DATEVER;
            `RADIANT_REG_MASK:    rd_word = axil_data_t'(mask_i);
            `RADIANT_REG_PPSCNT:  rd_word = pps_cnt_i;
            default: begin
                // scalers are zero-extended to the bus width
                if (scal_sel < `RADIANT_NUM_CH) begin
                    rd_word = axil_data_t'(scal_i[scal_sel]);
                end
            end
        endcase
    end

    // rvalid up the cycle after accept, down once taken
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (rd_start_i) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    // payload only loads on accept, so it holds under back-pressure
    // missing rd_en means an unmapped word
    always_ff @(posedge sysclk) begin
        if (rd_start_i) begin
            s_axil_rdata_o <= reg_if.rd_en ? rd_word : '0;
            s_axil_rresp_o <= reg_if.rd_en ? axil_resp_okay : axil_resp_slverr;
        end
    end

    a_rdata_stable: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o
        && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o));

    // reads of the 4..7 hole never arrive with rd_en
    a_rd_mapped: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        reg_if.rd_en |-> (reg_if.rd_idx <= `RADIANT_REG_PPSCNT)
        || (reg_if.rd_idx >= `RADIANT_REG_SCAL0));

endmodule

/* rtl/radiant_reg_if.sv */
// register access bundle from the bus front end
interface radiant_reg_if;

    import radiant_bus_pkg::*;

    // write side, single-cycle pulse
    logic wr_en;
    reg_idx_t wr_idx;
    axil_data_t wr_data;
    axil_strb_t wr_strb;

    // read side, single-cycle pulse
    logic rd_en;
    reg_idx_t rd_idx;

    // front end drives everything
    modport decode (
        output wr_en,
        output wr_idx,
        output wr_data,
        output wr_strb,
        output rd_en,
        output rd_idx
    );

    // scaler bank owns the writable registers
    modport execute (
        input wr_en,
        input wr_idx,
        input wr_data,
        input wr_strb
    );

    // read mux only needs the read half
    modport result (
        input rd_en,
        input rd_idx
    );

endinterface

/* rtl/radiant_scal_pkg.sv */
`include "radiant_cfg.svh"

package radiant_scal_pkg;

    // one bit per trigger channel
    // used for the raw inputs, edges and the disable mask
    typedef logic [`RADIANT_NUM_CH-1:0] ch_mask_t;

    // single scaler count
    typedef logic [`RADIANT_SCAL_W-1:0] scal_cnt_t;

    // whole scaler bank, channel 0 in the low slice
    typedef scal_cnt_t [`RADIANT_NUM_CH-1:0] scal_array_t;

    // counters stick here instead of wrapping
    localparam scal_cnt_t scal_max = '1;

endpackage

/* rtl/radiant_scaler_bank.sv */
`include "radiant_cfg.svh"

module radiant_scaler_bank
    import radiant_bus_pkg::*, radiant_scal_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    // asynchronous board inputs
    input  ch_mask_t             trig_i,
    input  logic                 pps_i,
    radiant_reg_if.execute       reg_if,
    // channel disable mask, 1 = ignored
    output ch_mask_t             mask_o,
    // number of PPS latches since reset
    output axil_data_t           pps_cnt_o,
    // counts frozen at the last PPS
    output scal_array_t          scal_o
);

    ch_mask_t trig_s1;
    ch_mask_t trig_s2;
    ch_mask_t trig_s3;
    logic pps_s1;
    logic pps_s2;
    logic pps_s3;
    ch_mask_t trig_rise;
    logic pps_rise;
    scal_array_t cnt;
    axil_data_t mask_wr;

    // 2-flop sync, third flop for edge detect
    // polarity fixed before the sync so every channel idles low
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trig_s1 <= '0;
            trig_s2 <= '0;
            trig_s3 <= '0;
            pps_s1 <= 1'b0;
            pps_s2 <= 1'b0;
            pps_s3 <= 1'b0;
        end else begin
            trig_s1 <= trig_i ^ `RADIANT_TRIG_POL;
            trig_s2 <= trig_s1;
            trig_s3 <= trig_s2;
            pps_s1 <= pps_i;
            pps_s2 <= pps_s1;
            pps_s3 <= pps_s2;
        end
    end

    // rising edges, disabled channels dropped here
    assign trig_rise = trig_s2 & ~trig_s3 & ~mask_o;
    assign pps_rise = pps_s2 & ~pps_s3;

    // byte-lane merge of the write data into the current mask
    always_comb begin
        mask_wr = axil_data_t'(mask_o);
        for (int b = 0; b < $bits(axil_strb_t); b++) begin
            if (reg_if.wr_strb[b]) begin
                mask_wr[b*8 +: 8] = reg_if.wr_data[b*8 +: 8];
            end
        end
    end

    // mask register, upper bits beyond the channel count are dropped
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_o <= '0;
        end else if (reg_if.wr_en) begin
            mask_o <= mask_wr[`RADIANT_NUM_CH-1:0];
        end
    end

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt <= '0;
            scal_o <= '0;
            pps_cnt_o <= '0;
        end else begin
            // snapshot the running counts once per second
            if (pps_rise) begin
                scal_o <= cnt;
                pps_cnt_o <= pps_cnt_o + 1'b1;
            end
            for (int ch = 0; ch < `RADIANT_NUM_CH; ch++) begin
                if (pps_rise) begin
                    // an edge on the latch cycle opens the new period
                    cnt[ch] <= scal_cnt_t'(trig_rise[ch]);
                end else if (trig_rise[ch] && (cnt[ch] != scal_max)) begin
                    cnt[ch] <= cnt[ch] + 1'b1;
                end
            end
        end
    end

    // the front end only ever forwards writes aimed at the mask
    a_wr_mask: assert property (@(posedge sysclk) disable iff (!arst_n_i)
        reg_if.wr_en |-> reg_if.wr_idx == `RADIANT_REG_MASK);

    for (genvar g = 0; g < `RADIANT_NUM_CH; g++) begin : g_chk
        // a full counter stays full until the next latch
        a_sat: assert property (@(posedge sysclk) disable iff (!arst_n_i)
            (cnt[g] == scal_max) && !pps_rise |=> cnt[g] == scal_max);
    end

endmodule

/* rtl/radiant_top.sv */
module radiant_top
    import radiant_bus_pkg::*, radiant_scal_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    // AXI4-Lite slave
    input  axil_addr_t           s_axil_awaddr_i,
    input  logic                 s_axil_awvalid_i,
    output logic                 s_axil_awready_o,
    input  axil_data_t           s_axil_wdata_i,
    input  axil_strb_t           s_axil_wstrb_i,
    input  logic                 s_axil_wvalid_i,
    output logic                 s_axil_wready_o,
    output axil_resp_t           s_axil_bresp_o,
    output logic                 s_axil_bvalid_o,
    input  logic                 s_axil_bready_i,
    input  axil_addr_t           s_axil_araddr_i,
    input  logic                 s_axil_arvalid_i,
    output logic                 s_axil_arready_o,
    output axil_data_t           s_axil_rdata_o,
    output axil_resp_t           s_axil_rresp_o,
    output logic                 s_axil_rvalid_o,
    input  logic                 s_axil_rready_i,
    // trigger comparators and PPS, both asynchronous
    input  ch_mask_t             trig_i,
    input  logic                 pps_i
);

    logic rd_start;
    ch_mask_t mask;
    axil_data_t pps_cnt;
    scal_array_t scal;

    radiant_reg_if reg_if ();

    // bus front end
    radiant_axil_decode u_decode (
        .sysclk            (sysclk),
        .arst_n_i          (arst_n_i),
        .s_axil_awaddr_i   (s_axil_awaddr_i),
        .s_axil_awvalid_i  (s_axil_awvalid_i),
        .s_axil_awready_o  (s_axil_awready_o),
        .s_axil_wdata_i    (s_axil_wdata_i),
        .s_axil_wstrb_i    (s_axil_wstrb_i),
        .s_axil_wvalid_i   (s_axil_wvalid_i),
        .s_axil_wready_o   (s_axil_wready_o),
        .s_axil_bresp_o    (s_axil_bresp_o),
        .s_axil_bvalid_o   (s_axil_bvalid_o),
        .s_axil_bready_i   (s_axil_bready_i),
        .s_axil_araddr_i   (s_axil_araddr_i),
        .s_axil_arvalid_i  (s_axil_arvalid_i),
        .s_axil_arready_o  (s_axil_arready_o),
        .s_axil_rvalid_i   (s_axil_rvalid_o),
        .s_axil_rd_start_o (rd_start),
        .reg_if            (reg_if)
    );

    // scalers and mask register
    radiant_scaler_bank u_scaler_bank (
        .sysclk    (sysclk),
        .arst_n_i  (arst_n_i),
        .trig_i    (trig_i),
        .pps_i     (pps_i),
        .reg_if    (reg_if),
        .mask_o    (mask),
        .pps_cnt_o (pps_cnt),
        .scal_o    (scal)
    );

    // read mux and response register
    radiant_read_result u_read_result (
        .sysclk          (sysclk),
        .arst_n_i        (arst_n_i),
        .rd_start_i      (rd_start),
        .reg_if          (reg_if),
        .mask_i          (mask),
        .pps_cnt_i       (pps_cnt),
        .scal_i          (scal),
        .s_axil_rdata_o  (s_axil_rdata_o),
        .s_axil_rresp_o  (s_axil_rresp_o),
        .s_axil_rvalid_o (s_axil_rvalid_o),
        .s_axil_rready_i (s_axil_rready_i)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project root"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module tb_radiant_top \
    -f flist.f \
    -o tb_radiant_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_radiant_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

/* test/tb_radiant_tasks.svh */
`ifndef TB_RADIANT_TASKS_SVH
`define TB_RADIANT_TASKS_SVH

// cycles any single wait may take
localparam int wait_limit = 50;
// response codes
localparam axil_resp_t resp_okay = 2'b00;
localparam axil_resp_t resp_slverr = 2'b10;

task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "run aborted");
endtask

task automatic check_eq(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(posedge sysclk);
endtask

// aw and w presented together
task automatic drive_write(input reg_idx_t idx, input axil_data_t data, input axil_strb_t strb);
    @(posedge sysclk);
    awaddr <= {idx, 2'b00};
    wdata <= data;
    wstrb <= strb;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
endtask

task automatic wait_write_accept();
    int n;
    n = 0;
    @(negedge sysclk);
    while (awready !== 1'b1) begin
        n++;
        if (n > wait_limit) begin
            $display("timeout at %0t: write address and data never accepted", $time);
            abort_run();
        end
        @(negedge sysclk);
    end
    check_eq("wready", axil_data_t'(wready), 32'd1);
    // handshake lands on this edge
    @(posedge sysclk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
endtask

task automatic wait_bvalid();
    int n;
    n = 0;
    @(negedge sysclk);
    while (bvalid !== 1'b1) begin
        n++;
        if (n > wait_limit) begin
            $display("timeout at %0t: write response never came", $time);
            abort_run();
        end
        @(negedge sysclk);
    end
endtask

// needs bready high
task automatic take_bresp(output axil_resp_t resp);
    wait_bvalid();
    resp = bresp;
    @(posedge sysclk);
endtask

task automatic axil_write(input reg_idx_t idx, input axil_data_t data, input axil_strb_t strb,
                          output axil_resp_t resp);
    drive_write(idx, data, strb);
    wait_write_accept();
    take_bresp(resp);
endtask

task automatic drive_read(input reg_idx_t idx);
    @(posedge sysclk);
    araddr <= {idx, 2'b00};
    arvalid <= 1'b1;
endtask

// needs arvalid already high
task automatic wait_read_accept();
    int n;
    n = 0;
    @(negedge sysclk);
    while (arready !== 1'b1) begin
        n++;
        if (n > wait_limit) begin
            $display("timeout at %0t: read address never accepted", $time);
            abort_run();
        end
        @(negedge sysclk);
    end
    @(posedge sysclk);
    arvalid <= 1'b0;
endtask

task automatic send_read(input reg_idx_t idx);
    drive_read(idx);
    wait_read_accept();
endtask

task automatic wait_rvalid();
    int n;
    n = 0;
    @(negedge sysclk);
    while (rvalid !== 1'b1) begin
        n++;
        if (n > wait_limit) begin
            $display("timeout at %0t: read data never came", $time);
            abort_run();
        end
        @(negedge sysclk);
    end
endtask

// needs rready high
task automatic take_rdata(output axil_data_t data, output axil_resp_t resp);
    wait_rvalid();
    data = rdata;
    resp = rresp;
    @(posedge sysclk);
endtask

task automatic axil_read(input reg_idx_t idx, output axil_data_t data, output axil_resp_t resp);
    send_read(idx);
    take_rdata(data, resp);
endtask

// read one word and compare data and response
task automatic read_expect(input string name, input reg_idx_t idx, input axil_data_t exp,
                           input axil_resp_t exp_resp);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(idx, data, resp);
    check_eq(name, data, exp);
    check_eq({name, " rresp"}, axil_data_t'(resp), axil_data_t'(exp_resp));
endtask

// 3 cycles active, 3 idle, per pulse_cnt entry
task automatic pulse_triggers();
    int unsigned longest;
    ch_mask_t active;
    longest = 0;
    for (int ch = 0; ch < `RADIANT_NUM_CH; ch++) begin
        if (pulse_cnt[ch] > longest) begin
            longest = pulse_cnt[ch];
        end
    end
    for (int unsigned i = 0; i < longest; i++) begin
        active = '0;
        for (int ch = 0; ch < `RADIANT_NUM_CH; ch++) begin
            active[ch] = (pulse_cnt[ch] > i);
        end
        @(posedge sysclk);
        // active-low channels toggle down
        trig <= `RADIANT_TRIG_POL ^ active;
        wait_cycles(3);
        trig <= `RADIANT_TRIG_POL;
        wait_cycles(2);
    end
endtask

task automatic pulse_pps();
    @(posedge sysclk);
    pps <= 1'b1;
    wait_cycles(3);
    pps <= 1'b0;
    pps_seen = pps_seen + 32'd1;
    // latch lands 3 cycles after the edge
    wait_cycles(6);
endtask

// every scaler plus the PPS count for the period just closed
task automatic check_period(input ch_mask_t disabled);
    axil_data_t exp;
    for (int ch = 0; ch < `RADIANT_NUM_CH; ch++) begin
        exp = disabled[ch] ? '0 : axil_data_t'(pulse_cnt[ch]);
        read_expect($sformatf("scaler %0d", ch), reg_idx_t'(`RADIANT_REG_SCAL0 + ch), exp,
                    resp_okay);
    end
    read_expect("pps count", `RADIANT_REG_PPSCNT, pps_seen, resp_okay);
endtask

task automatic clear_pulses();
    for (int ch = 0; ch < `RADIANT_NUM_CH; ch++) begin
        pulse_cnt[ch] = 0;
    end
endtask

task automatic after_reset_values();
    @(negedge sysclk);
    check_eq("awready", axil_data_t'(awready), '0);
    check_eq("wready", axil_data_t'(wready), '0);
    check_eq("bvalid", axil_data_t'(bvalid), '0);
    check_eq("rvalid", axil_data_t'(rvalid), '0);
    check_eq("arready", axil_data_t'(arready), 32'd1);
    read_expect("ident", `RADIANT_REG_ID, `RADIANT_IDENT, resp_okay);
    read_expect("datever", `RADIANT_REG_DATEVER, `RADIANT_DATEVER, resp_okay);
    read_expect("mask", `RADIANT_REG_MASK, '0, resp_okay);
    read_expect("pps count", `RADIANT_REG_PPSCNT, '0, resp_okay);
    read_expect("scaler 0", `RADIANT_REG_SCAL0, '0, resp_okay);
endtask

task automatic mask_byte_lanes();
    axil_data_t old;
    axil_data_t wval;
    axil_resp_t resp;
    // top byte set on purpose, only 24 bits exist
    old = $urandom() | 32'hff00_0000;
    axil_write(`RADIANT_REG_MASK, old, 4'b1111, resp);
    check_eq("mask bresp", axil_data_t'(resp), axil_data_t'(resp_okay));
    old = old & 32'h00ff_ffff;
    read_expect("mask full", `RADIANT_REG_MASK, old, resp_okay);
    wval = $urandom();
    axil_write(`RADIANT_REG_MASK, wval, 4'b0101, resp);
    check_eq("mask lanes bresp", axil_data_t'(resp), axil_data_t'(resp_okay));
    // lanes 0 and 2 take new data, lane 1 keeps the old byte
    read_expect("mask lanes 0/2", `RADIANT_REG_MASK,
                (wval & 32'h00ff_00ff) | (old & 32'h0000_ff00), resp_okay);
    axil_write(`RADIANT_REG_MASK, '0, 4'b1111, resp);
    read_expect("mask cleared", `RADIANT_REG_MASK, '0, resp_okay);
endtask

task automatic scaler_counting();
    int chans [6];
    // both polarities represented
    chans = '{0, 2, 7, 13, 18, 23};
    clear_pulses();
    foreach (chans[i]) begin
        pulse_cnt[chans[i]] = $urandom_range(20, 1);
    end
    pulse_triggers();
    wait_cycles(6);
    pulse_pps();
    check_period('0);
    // quiet second period
    clear_pulses();
    wait_cycles(6);
    pulse_pps();
    check_period('0);
endtask

task automatic masked_channel();
    axil_resp_t resp;
    axil_write(`RADIANT_REG_MASK, 32'h0000_0010, 4'b1111, resp);
    check_eq("mask bresp", axil_data_t'(resp), axil_data_t'(resp_okay));
    clear_pulses();
    pulse_cnt[4] = $urandom_range(20, 1);
    pulse_cnt[9] = $urandom_range(20, 1);
    pulse_triggers();
    wait_cycles(6);
    pulse_pps();
    // channel 4 disabled, channel 9 counts
    check_period(24'h00_0010);
    axil_write(`RADIANT_REG_MASK, '0, 4'b1111, resp);
endtask

task automatic error_responses();
    axil_resp_t resp;
    axil_write(`RADIANT_REG_ID, $urandom(), 4'b1111, resp);
    check_eq("ident write bresp", axil_data_t'(resp), axil_data_t'(resp_slverr));
    read_expect("ident after write", `RADIANT_REG_ID, `RADIANT_IDENT, resp_okay);
    // index 5 sits in the hole
    read_expect("hole read", 5'd5, '0, resp_slverr);
endtask

task automatic back_pressure();
    axil_data_t held;
    axil_data_t wval;
    axil_resp_t resp;
    // read side
    @(posedge sysclk);
    rready <= 1'b0;
    send_read(`RADIANT_REG_ID);
    wait_rvalid();
    held = rdata;
    check_eq("held rdata", held, `RADIANT_IDENT);
    // second read queued behind the held response
    drive_read(`RADIANT_REG_DATEVER);
    repeat (10) begin
        @(negedge sysclk);
        check_eq("rvalid", axil_data_t'(rvalid), 32'd1);
        check_eq("rdata", rdata, held);
        check_eq("arready", axil_data_t'(arready), '0);
    end
    @(posedge sysclk);
    rready <= 1'b1;
    take_rdata(held, resp);
    check_eq("released rdata", held, `RADIANT_IDENT);
    wait_read_accept();
    take_rdata(held, resp);
    check_eq("queued rdata", held, `RADIANT_DATEVER);
    check_eq("queued rresp", axil_data_t'(resp), axil_data_t'(resp_okay));
    // write side
    @(posedge sysclk);
    bready <= 1'b0;
    drive_write(`RADIANT_REG_MASK, $urandom(), 4'b1111);
    wait_write_accept();
    wait_bvalid();
    wval = $urandom();
    // second write queued behind the held response
    drive_write(`RADIANT_REG_MASK, wval, 4'b1111);
    repeat (8) begin
        @(negedge sysclk);
        check_eq("bvalid", axil_data_t'(bvalid), 32'd1);
        check_eq("bresp", axil_data_t'(bresp), axil_data_t'(resp_okay));
        check_eq("awready", axil_data_t'(awready), '0);
        check_eq("wready", axil_data_t'(wready), '0);
    end
    @(posedge sysclk);
    bready <= 1'b1;
    take_bresp(resp);
    wait_write_accept();
    take_bresp(resp);
    check_eq("second bresp", axil_data_t'(resp), axil_data_t'(resp_okay));
    read_expect("mask after queue", `RADIANT_REG_MASK, wval & 32'h00ff_ffff, resp_okay);
    axil_write(`RADIANT_REG_MASK, '0, 4'b1111, resp);
endtask

`endif

/* test/tb_radiant_top.sv */
`include "radiant_cfg.svh"

module tb_radiant_top
    import radiant_bus_pkg::*, radiant_scal_pkg::*;
();

    logic sysclk;
    logic arst_n;

    // AXI4-Lite master side
    axil_addr_t awaddr;
    logic awvalid;
    logic awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic wvalid;
    logic wready;
    axil_resp_t bresp;
    logic bvalid;
    logic bready;
    axil_addr_t araddr;
    logic arvalid;
    logic arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic rvalid;
    logic rready;

    // board inputs
    ch_mask_t trig;
    logic pps;

    // pulses to send per channel in the current period
    int unsigned pulse_cnt [`RADIANT_NUM_CH];
    // PPS edges sent since reset
    axil_data_t pps_seen;

    `include "tb_radiant_tasks.svh"

    radiant_top u_dut (
        .sysclk           (sysclk),
        .arst_n_i         (arst_n),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .trig_i           (trig),
        .pps_i            (pps)
    );

    // 20 unit clock period
    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    initial begin
        void'($urandom(80));
        arst_n <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b1;
        // every channel parked at its idle level
        trig <= `RADIANT_TRIG_POL;
        pps <= 1'b0;
        pps_seen = '0;
        repeat (5) @(posedge sysclk);
        arst_n <= 1'b1;
        @(posedge sysclk);

        after_reset_values();
        mask_byte_lanes();
        scaler_counting();
        masked_channel();
        error_responses();
        back_pressure();

        $display("All checks passed");
        $finish;
    end

endmodule
